//--- tb/glb_vectors.txt
# columns: op name addr strb data expect err
# all numeric fields hex, err is the expected pslverr
apb_rd rst_ctrl_t0 000 0 0 0 0
apb_rd rst_cnt_t0 004 0 0 0 0
apb_rd rst_ctrl_t1 400 0 0 0 0
apb_rd rst_cnt_t1 404 0 0 0 0
apb_rd rst_ctrl_t2 800 0 0 0 0
apb_rd rst_cnt_t2 804 0 0 0 0
apb_rd rst_ctrl_t3 c00 0 0 0 0
apb_rd rst_cnt_t3 c04 0 0 0 0
proc_rd rst_rd_t1 0800 0 0 0 0
apb_wr en_t0 000 0 1 0 0
apb_rd en_rb_t0 000 0 0 1 0
proc_wr wr_full_t0 0008 ff 1122334455667788 0 0
proc_rd rd_full_t0 0008 0 0 1122334455667788 0
proc_wr wr_part_t0 0008 0f aaaaaaaabbbbbbbb 0 0
proc_rd rd_part_t0 0008 0 0 11223344bbbbbbbb 0
proc_wr wr_dis_t1 0810 ff deadbeefcafef00d 0 0
proc_rd rd_dis_t1 0810 0 0 0 0
apb_wr dis_t0 000 0 0 0 0
proc_wr wr_dis_t0 0008 ff 0123456789abcdef 0 0
proc_rd rd_dis_t0 0008 0 0 0 0
apb_wr reen_t0 000 0 1 0 0
proc_rd rd_kept_t0 0008 0 0 11223344bbbbbbbb 0
apb_rd cnt_t0 004 0 0 2 0
apb_rd cnt_t1 404 0 0 0 0
apb_wr wr_cnt_ro 004 0 55 0 1
apb_rd cnt_kept_t0 004 0 0 2 0
apb_wr wr_unmapped 008 0 0 0 1
apb_rd rd_unmapped 3fc 0 0 0 1
apb_rd ctrl_kept_t0 000 0 0 1 0
apb_wr en_t1 400 0 1 0 0
apb_wr en_t2 800 0 1 0 0
apb_wr en_t3 c00 0 1 0 0
idle settle 0 0 0 0 0

//--- project.f
common/glb_param_pkg.sv
common/glb_cfg_pkg.sv
glb_tile/glb_bank.sv
glb_tile/glb_tile_cfg.sv
glb_tile/glb_tile.sv
source/glb_apb_demux.sv
source/global_buffer.sv
tb/global_buffer_chk.sv
tb/glb_scoreboard.sv
tb/global_buffer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds global_buffer_tb with Verilator, runs it, keeps the output in sim.log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module global_buffer_tb -f project.f -o sim_glb \
    && ./obj_dir/sim_glb 2>&1 | tee sim.log \
    && ! grep -q "Test FAILED" sim.log \
    || { echo "global buffer simulation failed"; exit 1; }

echo "global buffer simulation passed"

//--- tb/global_buffer_tb.sv
//////////////////////////////////////////////////
// vector driven test of global_buffer
// vectors come from tb/glb_vectors.txt, run from root
// a random back-to-back block on all tiles follows
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module global_buffer_tb;
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;

    localparam int MAX_VEC  = 64;
    localparam int RAND_OPS = 3 * NUM_GLB_TILES;

    logic       clk;
    logic       rst;
    logic       proc_wr_en;
    bank_strb_t proc_wr_strb;
    glb_addr_t  proc_wr_addr;
    bank_data_t proc_wr_data;
    logic       proc_rd_en;
    glb_addr_t  proc_rd_addr;
    bank_data_t proc_rd_data;
    logic       proc_rd_data_valid;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pslverr;
    int         pass_cnt;
    int         fail_cnt;

    string      vec_op   [MAX_VEC];
    string      vec_name [MAX_VEC];
    logic [15:0] vec_addr [MAX_VEC];
    bank_strb_t vec_strb [MAX_VEC];
    bank_data_t vec_data [MAX_VEC];
    bank_data_t vec_exp  [MAX_VEC];
    logic       vec_err  [MAX_VEC];
    int         num_vec     = 0;
    int         tb_errors   = 0;
    int         cycle_cnt   = 0;
    int         cycle_limit = 0;
    integer     seed;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    global_buffer i_global_buffer (
        .clk                (clk),
        .rst                (rst),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pslverr            (pslverr)
    );

    glb_scoreboard i_glb_scoreboard (
        .clk                (clk),
        .rst                (rst),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .prdata             (prdata),
        .pslverr            (pslverr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .pass_cnt           (pass_cnt),
        .fail_cnt           (fail_cnt)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // setup phase, then one access phase
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t data,
                                input string name, input apb_data_t exp, input logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        i_glb_scoreboard.queue_apb(name, exp, err);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic proc_write(input glb_addr_t addr, input bank_strb_t strb,
                              input bank_data_t data);
        proc_wr_en   = 1'b1;
        proc_wr_strb = strb;
        proc_wr_addr = addr;
        proc_wr_data = data;
        next_cycle();
        proc_wr_en   = 1'b0;
    endtask

    task automatic proc_read(input glb_addr_t addr, input string name, input bank_data_t exp);
        proc_rd_en   = 1'b1;
        proc_rd_addr = addr;
        i_glb_scoreboard.queue_read(name, exp);
        next_cycle();
        proc_rd_en   = 1'b0;
    endtask

    // strobed bytes take the new word, the rest keep the old one
    function automatic bank_data_t merge_bytes(input bank_data_t old_word,
                                               input bank_data_t new_word,
                                               input bank_strb_t strb);
        bank_data_t mask;
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic int load_vectors();
        int              fd;
        int              code;
        string           line;
        logic [8*8-1:0]  op_r;
        logic [8*24-1:0] name_r;
        logic [15:0]     addr_r;
        bank_strb_t      strb_r;
        bank_data_t      data_r;
        bank_data_t      exp_r;
        logic            err_r;
        fd = $fopen("tb/glb_vectors.txt", "r");
        if (fd == 0) begin
            return 0;
        end
        while ($fgets(line, fd) != 0 && num_vec < MAX_VEC) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%s %s %h %h %h %h %h",
                               op_r, name_r, addr_r, strb_r, data_r, exp_r, err_r);
                if (code == 7) begin
                    vec_op[num_vec]   = string'(op_r);
                    vec_name[num_vec] = string'(name_r);
                    vec_addr[num_vec] = addr_r;
                    vec_strb[num_vec] = strb_r;
                    vec_data[num_vec] = data_r;
                    vec_exp[num_vec]  = exp_r;
                    vec_err[num_vec]  = err_r;
                    num_vec++;
                end else begin
                    $display("vector line could not be parsed: %s", line);
                    tb_errors++;
                end
            end
        end
        $fclose(fd);
        return num_vec;
    endfunction

    task automatic run_vector(input int i);
        if (vec_op[i] == "apb_wr") begin
            apb_transfer(1'b1, apb_addr_t'(vec_addr[i]), apb_data_t'(vec_data[i]),
                         vec_name[i], '0, vec_err[i]);
        end else if (vec_op[i] == "apb_rd") begin
            apb_transfer(1'b0, apb_addr_t'(vec_addr[i]), '0,
                         vec_name[i], apb_data_t'(vec_exp[i]), vec_err[i]);
        end else if (vec_op[i] == "proc_wr") begin
            proc_write(glb_addr_t'(vec_addr[i]), vec_strb[i], vec_data[i]);
        end else if (vec_op[i] == "proc_rd") begin
            proc_read(glb_addr_t'(vec_addr[i]), vec_name[i], vec_exp[i]);
        end else if (vec_op[i] == "idle") begin
            next_cycle();
        end else begin
            $display("vector %0d has an unknown operation %s", i, vec_op[i]);
            tb_errors++;
        end
    endtask

    // one word per tile, full write, partial overwrite, then reads in a row
    task automatic random_block();
        glb_addr_t  addr   [NUM_GLB_TILES];
        bank_data_t first  [NUM_GLB_TILES];
        bank_data_t second [NUM_GLB_TILES];
        bank_strb_t strb   [NUM_GLB_TILES];
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            addr[k]   = {tile_id_t'(k), bank_addr_t'(64 + k), 3'b000};
            first[k]  = {$random(seed), $random(seed)};
            second[k] = {$random(seed), $random(seed)};
            strb[k]   = bank_strb_t'($random(seed));
        end
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            proc_write(addr[k], '1, first[k]);
        end
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            proc_write(addr[k], strb[k], second[k]);
        end
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            proc_read(addr[k], $sformatf("rand_rd_t%0d", k),
                      merge_bytes(first[k], second[k], strb[k]));
        end
    endtask

    initial begin
        seed         = 32'he68a_3d71;
        rst          = 1'b1;
        proc_wr_en   = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        if (load_vectors() == 0) begin
            $display("no vectors could be read from tb/glb_vectors.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_limit = (num_vec + RAND_OPS) * (NUM_GLB_TILES + 3) + 50;
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int i = 0; i < num_vec; i++) begin
                run_vector(i);
            end
            random_block();
            while (i_glb_scoreboard.outstanding() != 0) begin
                next_cycle();
            end
            // catch late or stray responses
            repeat (NUM_GLB_TILES) next_cycle();
            $display("tests passed: %0d, failed: %0d, assertion failures: %0d, other errors: %0d",
                     pass_cnt, fail_cnt, i_global_buffer.i_global_buffer_chk.assert_fails,
                     tb_errors);
            if (fail_cnt == 0 && tb_errors == 0 && pass_cnt > 0
                && i_global_buffer.i_global_buffer_chk.assert_fails == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/glb_scoreboard.sv
//////////////////////////////////////////////////
// compares DUT responses with queued expectations
// APB checked in access phases, reads on valid
// responses must come back in issue order
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_scoreboard (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  glb_cfg_pkg::apb_data_t    prdata,
    input  logic                      pslverr,
    input  glb_param_pkg::bank_data_t proc_rd_data,
    input  logic                      proc_rd_data_valid,
    output int                        pass_cnt,
    output int                        fail_cnt
);
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;

    string      apb_name_q [$];
    apb_data_t  apb_data_q [$];
    logic       apb_err_q  [$];
    string      rd_name_q  [$];
    bank_data_t rd_data_q  [$];

    task automatic queue_apb(input string name, input apb_data_t data, input logic err);
        apb_name_q.push_back(name);
        apb_data_q.push_back(data);
        apb_err_q.push_back(err);
    endtask

    task automatic queue_read(input string name, input bank_data_t data);
        rd_name_q.push_back(name);
        rd_data_q.push_back(data);
    endtask

    function automatic int outstanding();
        return apb_name_q.size() + rd_name_q.size();
    endfunction

    task automatic record_result(input string name, input logic bad);
        if (bad) begin
            fail_cnt++;
        end else begin
            pass_cnt++;
            $display("passed %s", name);
        end
    endtask

    task automatic compare_apb();
        string     name;
        apb_data_t exp_data;
        logic      exp_err;
        logic      bad;
        name     = apb_name_q.pop_front();
        exp_data = apb_data_q.pop_front();
        exp_err  = apb_err_q.pop_front();
        bad      = 1'b0;
        // prdata only carries meaning on reads
        if (!pwrite && prdata !== exp_data) begin
            $display("[ERROR] %s: expected prdata %h, actual %h", name, exp_data, prdata);
            bad = 1'b1;
        end
        if (pslverr !== exp_err) begin
            $display("[ERROR] %s: expected pslverr %b, actual %b", name, exp_err, pslverr);
            bad = 1'b1;
        end
        record_result(name, bad);
    endtask

    task automatic compare_read();
        string      name;
        bank_data_t exp_data;
        name     = rd_name_q.pop_front();
        exp_data = rd_data_q.pop_front();
        if (proc_rd_data !== exp_data) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp_data, proc_rd_data);
        end
        record_result(name, proc_rd_data !== exp_data);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pass_cnt = 0;
            fail_cnt = 0;
        end else begin
            if (psel && penable) begin
                if (apb_name_q.size() == 0) begin
                    $display("APB access at %0t ns was not expected by any test", $time);
                    fail_cnt++;
                end else begin
                    compare_apb();
                end
            end
            if (proc_rd_data_valid) begin
                if (rd_name_q.size() == 0) begin
                    $display("read data came back at %0t ns with no read outstanding", $time);
                    fail_cnt++;
                end else begin
                    compare_read();
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/global_buffer_chk.sv
//////////////////////////////////////////////////
// bound into global_buffer
// read valid trails rd_en by the tile count
// pslverr only inside an APB access phase
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module global_buffer_chk (
    input  logic clk,
    input  logic rst,
    input  logic proc_rd_en,
    input  logic proc_rd_data_valid,
    input  logic psel,
    input  logic penable,
    input  logic pslverr
);
    import glb_param_pkg::*;

    int unsigned since_rst;
    // number of failed assertions so far
    int unsigned assert_fails = 0;

    // cycles since reset was released, saturating
    always @(posedge clk) begin
        if (rst) begin
            since_rst <= 0;
        end else if (since_rst < NUM_GLB_TILES) begin
            since_rst <= since_rst + 1;
        end
    end

    a_rd_latency: assert property (@(posedge clk) disable iff (rst)
        proc_rd_data_valid == $past(proc_rd_en, NUM_GLB_TILES))
        else begin
            assert_fails++;
            $error("read valid does not trail rd_en by the fixed latency");
        end

    a_err_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else begin
            assert_fails++;
            $error("pslverr raised outside an access phase");
        end

    a_quiet_after_rst: assert property (@(posedge clk) disable iff (rst)
        (since_rst < NUM_GLB_TILES) |-> !proc_rd_data_valid)
        else begin
            assert_fails++;
            $error("read valid seen too soon after reset");
        end

endmodule

bind global_buffer global_buffer_chk i_global_buffer_chk (
    .clk                (clk),
    .rst                (rst),
    .proc_rd_en         (proc_rd_en),
    .proc_rd_data_valid (proc_rd_data_valid),
    .psel               (psel),
    .penable            (penable),
    .pslverr            (pslverr)
);

`default_nettype wire

//--- source/global_buffer.sv
//////////////////////////////////////////////////
// row of tiles behind one processor port
// read data returns NUM_GLB_TILES cycles after rd_en
// no back-pressure, APB has no wait states
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module global_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        proc_wr_en,
    input  glb_param_pkg::bank_strb_t   proc_wr_strb,
    input  glb_param_pkg::glb_addr_t    proc_wr_addr,
    input  glb_param_pkg::bank_data_t   proc_wr_data,
    input  logic                        proc_rd_en,
    input  glb_param_pkg::glb_addr_t    proc_rd_addr,
    output glb_param_pkg::bank_data_t   proc_rd_data,
    output logic                        proc_rd_data_valid,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  glb_cfg_pkg::apb_addr_t      paddr,
    input  glb_cfg_pkg::apb_data_t      pwdata,
    output glb_cfg_pkg::apb_data_t      prdata,
    output logic                        pslverr
);
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;

    // lane element k is the west side of tile k
    logic       wr_en_int         [NUM_GLB_TILES+1];
    bank_strb_t wr_strb_int       [NUM_GLB_TILES+1];
    glb_addr_t  wr_addr_int       [NUM_GLB_TILES+1];
    bank_data_t wr_data_int       [NUM_GLB_TILES+1];
    logic       rd_en_int         [NUM_GLB_TILES+1];
    glb_addr_t  rd_addr_int       [NUM_GLB_TILES+1];
    bank_data_t rd_data_int       [NUM_GLB_TILES+1];
    logic       rd_data_valid_int [NUM_GLB_TILES+1];

    logic [NUM_GLB_TILES-1:0] tile_psel;
    apb_data_t                tile_prdata  [NUM_GLB_TILES];
    logic [NUM_GLB_TILES-1:0] tile_pslverr;

    assign wr_en_int[0]         = proc_wr_en;
    assign wr_strb_int[0]       = proc_wr_strb;
    assign wr_addr_int[0]       = proc_wr_addr;
    assign wr_data_int[0]       = proc_wr_data;
    assign rd_en_int[0]         = proc_rd_en;
    assign rd_addr_int[0]       = proc_rd_addr;
    // nothing enters the response lane from the west
    assign rd_data_int[0]       = '0;
    assign rd_data_valid_int[0] = 1'b0;

    assign proc_rd_data       = rd_data_int[NUM_GLB_TILES];
    assign proc_rd_data_valid = rd_data_valid_int[NUM_GLB_TILES];

    glb_apb_demux i_glb_apb_demux (
        .psel         (psel),
        .paddr        (paddr),
        .tile_prdata  (tile_prdata),
        .tile_pslverr (tile_pslverr),
        .tile_psel    (tile_psel),
        .prdata       (prdata),
        .pslverr      (pslverr)
    );

    for (genvar i = 0; i < NUM_GLB_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (tile_id_t'(i))
        ) i_glb_tile (
            .clk                (clk),
            .rst                (rst),
            .wr_en_wsti         (wr_en_int[i]),
            .wr_strb_wsti       (wr_strb_int[i]),
            .wr_addr_wsti       (wr_addr_int[i]),
            .wr_data_wsti       (wr_data_int[i]),
            .rd_en_wsti         (rd_en_int[i]),
            .rd_addr_wsti       (rd_addr_int[i]),
            .rd_data_wsti       (rd_data_int[i]),
            .rd_data_valid_wsti (rd_data_valid_int[i]),
            .wr_en_esto         (wr_en_int[i+1]),
            .wr_strb_esto       (wr_strb_int[i+1]),
            .wr_addr_esto       (wr_addr_int[i+1]),
            .wr_data_esto       (wr_data_int[i+1]),
            .rd_en_esto         (rd_en_int[i+1]),
            .rd_addr_esto       (rd_addr_int[i+1]),
            .rd_data_esto       (rd_data_int[i+1]),
            .rd_data_valid_esto (rd_data_valid_int[i+1]),
            .psel               (tile_psel[i]),
            .penable            (penable),
            .pwrite             (pwrite),
            .paddr              (paddr),
            .pwdata             (pwdata),
            .prdata             (tile_prdata[i]),
            .pslverr            (tile_pslverr[i])
        );
    end

endmodule

`default_nettype wire

//--- source/glb_apb_demux.sv
//////////////////////////////////////////////////
// routes psel to one tile by the tile field of paddr
// return path is zero while psel is low
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_apb_demux (
    input  logic                                    psel,
    input  glb_cfg_pkg::apb_addr_t                  paddr,
    input  glb_cfg_pkg::apb_data_t                  tile_prdata [glb_param_pkg::NUM_GLB_TILES],
    input  logic [glb_param_pkg::NUM_GLB_TILES-1:0] tile_pslverr,
    output logic [glb_param_pkg::NUM_GLB_TILES-1:0] tile_psel,
    output glb_cfg_pkg::apb_data_t                  prdata,
    output logic                                    pslverr
);
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;

    tile_id_t sel_id;

    assign sel_id = paddr[CFG_TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH];

    always_comb begin
        tile_psel = '0;
        prdata    = '0;
        pslverr   = 1'b0;
        if (psel) begin
            for (int i = 0; i < NUM_GLB_TILES; i++) begin
                // at most one tile id can match
                if (sel_id == tile_id_t'(i)) begin
                    tile_psel[i] = 1'b1;
                    prdata       = tile_prdata[i];
                    pslverr      = tile_pslverr[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- glb_tile/glb_tile.sv
//////////////////////////////////////////////////
// one pipeline stage of the request and response lanes
// a disabled tile drops writes and returns zero reads
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_tile #(
    parameter glb_param_pkg::tile_id_t TILE_ID = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en_wsti,
    input  glb_param_pkg::bank_strb_t   wr_strb_wsti,
    input  glb_param_pkg::glb_addr_t    wr_addr_wsti,
    input  glb_param_pkg::bank_data_t   wr_data_wsti,
    input  logic                        rd_en_wsti,
    input  glb_param_pkg::glb_addr_t    rd_addr_wsti,
    input  glb_param_pkg::bank_data_t   rd_data_wsti,
    input  logic                        rd_data_valid_wsti,
    output logic                        wr_en_esto,
    output glb_param_pkg::bank_strb_t   wr_strb_esto,
    output glb_param_pkg::glb_addr_t    wr_addr_esto,
    output glb_param_pkg::bank_data_t   wr_data_esto,
    output logic                        rd_en_esto,
    output glb_param_pkg::glb_addr_t    rd_addr_esto,
    output glb_param_pkg::bank_data_t   rd_data_esto,
    output logic                        rd_data_valid_esto,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  glb_cfg_pkg::apb_addr_t      paddr,
    input  glb_cfg_pkg::apb_data_t      pwdata,
    output glb_cfg_pkg::apb_data_t      prdata,
    output logic                        pslverr
);
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;

    logic       tile_en;
    logic       wr_hit;
    logic       rd_hit;
    logic       wr_accepted;
    bank_data_t bank_rd_data;
    bank_data_t rd_data_q;
    logic       rd_data_valid_q;
    logic       rd_own_q;
    logic       rd_own_en_q;

    assign wr_hit      = wr_en_wsti && (wr_addr_wsti[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH] == TILE_ID);
    assign rd_hit      = rd_en_wsti && (rd_addr_wsti[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH] == TILE_ID);
    assign wr_accepted = wr_hit & tile_en;

    // request lane, one register per tile
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en_esto <= 1'b0;
            rd_en_esto <= 1'b0;
        end else begin
            wr_en_esto <= wr_en_wsti;
            rd_en_esto <= rd_en_wsti;
        end
        wr_strb_esto <= wr_strb_wsti;
        wr_addr_esto <= wr_addr_wsti;
        wr_data_esto <= wr_data_wsti;
        rd_addr_esto <= rd_addr_wsti;
    end

    // response lane stage, bank data lands in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_valid_q <= 1'b0;
            rd_own_q        <= 1'b0;
            rd_own_en_q     <= 1'b0;
        end else begin
            rd_data_valid_q <= rd_data_valid_wsti;
            rd_own_q        <= rd_hit;
            rd_own_en_q     <= rd_hit & tile_en;
        end
        rd_data_q <= rd_data_wsti;
    end

    assign rd_data_esto       = rd_own_q ? (rd_own_en_q ? bank_rd_data : '0) : rd_data_q;
    assign rd_data_valid_esto = rd_own_q | rd_data_valid_q;

    glb_bank i_glb_bank (
        .clk     (clk),
        .wr_en   (wr_accepted),
        .wr_strb (wr_strb_wsti),
        .wr_addr (wr_addr_wsti[BANK_BYTE_OFFSET +: BANK_ADDR_WIDTH]),
        .wr_data (wr_data_wsti),
        .rd_en   (rd_hit & tile_en),
        .rd_addr (rd_addr_wsti[BANK_BYTE_OFFSET +: BANK_ADDR_WIDTH]),
        .rd_data (bank_rd_data)
    );

    glb_tile_cfg i_glb_tile_cfg (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .wr_accepted (wr_accepted),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .tile_en     (tile_en)
    );

endmodule

`default_nettype wire

//--- glb_tile/glb_tile_cfg.sv
//////////////////////////////////////////////////
// CTRL and WR_CNT of one tile
// access completes with psel and penable high
// WR_CNT is read-only and saturates
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_tile_cfg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  glb_cfg_pkg::apb_addr_t  paddr,
    input  glb_cfg_pkg::apb_data_t  pwdata,
    input  logic                    wr_accepted,
    output glb_cfg_pkg::apb_data_t  prdata,
    output logic                    pslverr,
    output logic                    tile_en
);
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;

    logic                        access;
    logic                        ctrl_hit;
    logic                        cnt_hit;
    logic [WR_CNT_WIDTH-1:0]     wr_cnt;
    logic [CFG_OFFSET_WIDTH-1:0] offset;

    assign offset   = paddr[CFG_OFFSET_WIDTH-1:0];
    assign access   = psel & penable;
    assign ctrl_hit = (offset == CFG_CTRL_OFFSET);
    assign cnt_hit  = (offset == CFG_WR_CNT_OFFSET);

    // only CTRL is writable
    assign pslverr = access & (pwrite ? !ctrl_hit : !(ctrl_hit | cnt_hit));

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (ctrl_hit) begin
                prdata = apb_data_t'(tile_en);
            end else if (cnt_hit) begin
                prdata = apb_data_t'(wr_cnt);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tile_en <= 1'b0;
            wr_cnt  <= '0;
        end else begin
            if (access && pwrite && ctrl_hit) begin
                tile_en <= pwdata[0];
            end
            // stick at all ones
            if (wr_accepted && !(&wr_cnt)) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- glb_tile/glb_bank.sv
//////////////////////////////////////////////////
// 256 x 64 bank, one write and one read port
// read data registered one cycle, read-first
// contents are undefined after power-up
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_bank (
    input  logic                        clk,
    input  logic                        wr_en,
    input  glb_param_pkg::bank_strb_t   wr_strb,
    input  glb_param_pkg::bank_addr_t   wr_addr,
    input  glb_param_pkg::bank_data_t   wr_data,
    input  logic                        rd_en,
    input  glb_param_pkg::bank_addr_t   rd_addr,
    output glb_param_pkg::bank_data_t   rd_data
);
    import glb_param_pkg::*;

    bank_data_t mem [2**BANK_ADDR_WIDTH];

    // byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // same-address write in this cycle is not seen here
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- common/glb_cfg_pkg.sv
//////////////////////////////////////////////////
// APB widths and the register map of one tile
// top address bits pick the tile, low bits the offset
//////////////////////////////////////////////////
`default_nettype none

package glb_cfg_pkg;
    import glb_param_pkg::*;

    localparam int APB_ADDR_WIDTH   = 12;
    localparam int APB_DATA_WIDTH   = 32;
    localparam int CFG_TILE_SEL_LSB = APB_ADDR_WIDTH - TILE_SEL_ADDR_WIDTH;
    localparam int CFG_OFFSET_WIDTH = CFG_TILE_SEL_LSB;
    localparam int WR_CNT_WIDTH     = 16;

    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_CTRL_OFFSET   = 'h0;
    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_WR_CNT_OFFSET = 'h4;

    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

endpackage

`default_nettype wire

//--- common/glb_param_pkg.sv
//////////////////////////////////////////////////
// buffer geometry shared by every tile
// processor byte address is tile, word, byte offset
// read latency equals the number of tiles
//////////////////////////////////////////////////
`default_nettype none

package glb_param_pkg;

    localparam int NUM_GLB_TILES       = 4;
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int BANK_ADDR_WIDTH     = 8;
    localparam int BANK_BYTE_OFFSET    = 3;
    localparam int GLB_ADDR_WIDTH      = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH + BANK_BYTE_OFFSET;
    localparam int TILE_SEL_LSB        = GLB_ADDR_WIDTH - TILE_SEL_ADDR_WIDTH;
    localparam int BANK_DATA_WIDTH     = 64;
    localparam int BANK_STRB_WIDTH     = BANK_DATA_WIDTH / 8;

    typedef logic [GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0]     bank_addr_t;
    typedef logic [BANK_DATA_WIDTH-1:0]     bank_data_t;
    typedef logic [BANK_STRB_WIDTH-1:0]     bank_strb_t;
    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;

endpackage

`default_nettype wire
